//--- armPipeTop.f
design/armIsaPkg.sv
design/pipeCfgPkg.sv
design/fetchStage.sv
design/regFile.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/hazardUnit.sv
design/armPipeTop.sv
sim/hazardUnit_properties.sv
sim/armPipeTb.sv

//--- design/armIsaPkg.sv
package armIsaPkg;

  typedef logic [31:0] wordT;   // Data word or byte address
  typedef logic [3:0]  regAddrT; // r0..r15

  // ALU operation, 2 bits
  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluCtrlT;

  // Immediate kinds of the reduced subset, both zero-extended
  typedef enum logic {
    immDp8   = 1'b0, // DP operand2 imm8, no rotate
    immMem12 = 1'b1  // LDR/STR positive offset
  } immSrcT;

  // op field, instr[27:26]
  localparam logic [1:0] opDp  = 2'b00;
  localparam logic [1:0] opMem = 2'b01;

  // cmd field of data processing, instr[24:21]
  localparam logic [3:0] cmdAnd = 4'b0000;
  localparam logic [3:0] cmdSub = 4'b0010;
  localparam logic [3:0] cmdAdd = 4'b0100;
  localparam logic [3:0] cmdOrr = 4'b1100;

  // Low bit of each instruction field
  localparam int instrOpLsb  = 26; // 2 bits
  localparam int instrIBit   = 25; // Immediate operand for DP
  localparam int instrCmdLsb = 21; // 4 bits
  localparam int instrLBit   = 20; // Load when set, memory ops only
  localparam int instrRnLsb  = 16;
  localparam int instrRdLsb  = 12;
  localparam int instrRmLsb  = 0;

endpackage

//--- design/armPipeTop.sv
module armPipeTop #(
  parameter armIsaPkg::wordT resetPc = pipeCfgPkg::defaultResetPc
) (
  input  logic               clk,
  input  logic               rstN,
  input  armIsaPkg::wordT    instrF,
  input  armIsaPkg::wordT    readDataM,
  output armIsaPkg::wordT    pcF,
  output armIsaPkg::wordT    aluOutM,
  output armIsaPkg::wordT    writeDataM,
  output armIsaPkg::wordT    resultW,
  output logic               memWriteM,
  output logic               regWriteW,
  output armIsaPkg::regAddrT wa3W
);
  import armIsaPkg::*;
  import pipeCfgPkg::*;

  wordT    pcPlus4F;
  wordT    instrD;
  regAddrT ra1D;
  regAddrT ra2D;
  regAddrT ra1E;
  regAddrT ra2E;
  regAddrT wa3E;
  regAddrT wa3M;
  wordT    rd1E;
  wordT    rd2E;
  wordT    extImmE;
  aluCtrlT aluCtrlE;
  logic    aluSrcE;
  logic    regWriteE;
  logic    memWriteE;
  logic    memToRegE;
  logic    regWriteM;
  logic    memToRegM;
  fwdSelT  forwardA;
  fwdSelT  forwardB;
  logic    stallF;
  logic    stallD;
  logic    flushE;

  fetchStage #(
    .resetPc (resetPc)
  ) fetch0 (
    .clk      (clk),
    .rstN     (rstN),
    .stallF   (stallF),
    .stallD   (stallD),
    .instrF   (instrF),
    .pcF      (pcF),
    .pcPlus4F (pcPlus4F),
    .instrD   (instrD)
  );

  decodeStage decode0 (
    .clk       (clk),
    .rstN      (rstN),
    .flushE    (flushE),
    .instrD    (instrD),
    .pcPlus4F  (pcPlus4F),
    .regWriteW (regWriteW),
    .wa3W      (wa3W),
    .resultW   (resultW),
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .wa3E      (wa3E),
    .rd1E      (rd1E),
    .rd2E      (rd2E),
    .extImmE   (extImmE),
    .aluCtrlE  (aluCtrlE),
    .aluSrcE   (aluSrcE),
    .regWriteE (regWriteE),
    .memWriteE (memWriteE),
    .memToRegE (memToRegE)
  );

  executeStage execute0 (
    .clk        (clk),
    .rstN       (rstN),
    .rd1E       (rd1E),
    .rd2E       (rd2E),
    .extImmE    (extImmE),
    .wa3E       (wa3E),
    .aluCtrlE   (aluCtrlE),
    .aluSrcE    (aluSrcE),
    .regWriteE  (regWriteE),
    .memWriteE  (memWriteE),
    .memToRegE  (memToRegE),
    .forwardA   (forwardA),
    .forwardB   (forwardB),
    .resultW    (resultW),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .wa3M       (wa3M),
    .regWriteM  (regWriteM),
    .memWriteM  (memWriteM),
    .memToRegM  (memToRegM)
  );

  memWbStage memWb0 (
    .clk       (clk),
    .rstN      (rstN),
    .aluOutM   (aluOutM),
    .readDataM (readDataM),
    .wa3M      (wa3M),
    .regWriteM (regWriteM),
    .memToRegM (memToRegM),
    .regWriteW (regWriteW),
    .wa3W      (wa3W),
    .resultW   (resultW)
  );

  hazardUnit hazard0 (
    .ra1D      (ra1D),
    .ra2D      (ra2D),
    .ra1E      (ra1E),
    .ra2E      (ra2E),
    .wa3E      (wa3E),
    .wa3M      (wa3M),
    .wa3W      (wa3W),
    .memToRegE (memToRegE),
    .regWriteM (regWriteM),
    .regWriteW (regWriteW),
    .forwardA  (forwardA),
    .forwardB  (forwardB),
    .stallF    (stallF),
    .stallD    (stallD),
    .flushE    (flushE)
  );

endmodule

//--- design/decodeStage.sv
module decodeStage (
  input  logic               clk,
  input  logic               rstN,
  input  logic               flushE,
  input  armIsaPkg::wordT    instrD,
  input  armIsaPkg::wordT    pcPlus4F,  // r15 value for this instruction
  input  logic               regWriteW,
  input  armIsaPkg::regAddrT wa3W,
  input  armIsaPkg::wordT    resultW,
  output armIsaPkg::regAddrT ra1D,
  output armIsaPkg::regAddrT ra2D,
  output armIsaPkg::regAddrT ra1E,
  output armIsaPkg::regAddrT ra2E,
  output armIsaPkg::regAddrT wa3E,
  output armIsaPkg::wordT    rd1E,
  output armIsaPkg::wordT    rd2E,
  output armIsaPkg::wordT    extImmE,
  output armIsaPkg::aluCtrlT aluCtrlE,
  output logic               aluSrcE,
  output logic               regWriteE,
  output logic               memWriteE,
  output logic               memToRegE
);
  import armIsaPkg::*;

  logic [1:0] op;
  logic [3:0] cmd;
  logic       immBit;
  logic       loadBit;
  logic       isNop;
  logic       isStore;
  regAddrT    wa3D;
  wordT       rd1D;
  wordT       rd2D;
  wordT       extImmD;
  aluCtrlT    aluCtrlD;
  immSrcT     immSrcD;
  logic       aluSrcD;
  logic       regWriteD;
  logic       memWriteD;
  logic       memToRegD;

  assign op      = instrD[instrOpLsb +: 2];
  assign cmd     = instrD[instrCmdLsb +: 4];
  assign immBit  = instrD[instrIBit];
  assign loadBit = instrD[instrLBit];
  assign isNop   = (instrD == '0); // andeq r0,r0,r0, the reset value of instrD
  assign isStore = (op == opMem) && !loadBit;

  // Source and destination indexes
  assign wa3D = instrD[instrRdLsb +: 4];
  assign ra1D = instrD[instrRnLsb +: 4]; // Rn, or the base for LDR/STR
  assign ra2D = isStore ? wa3D : instrD[instrRmLsb +: 4]; // STR reads its data from Rd

  // Control decoder, condition field ignored
  always_comb begin
    aluCtrlD  = aluAdd;
    aluSrcD   = 1'b0;
    immSrcD   = immDp8;
    regWriteD = 1'b0;
    memWriteD = 1'b0;
    memToRegD = 1'b0;
    if (!isNop) begin
      case (op)
        opDp: begin
          aluSrcD   = immBit;
          regWriteD = 1'b1;
          case (cmd)
            cmdAdd:  aluCtrlD = aluAdd;
            cmdSub:  aluCtrlD = aluSub;
            cmdAnd:  aluCtrlD = aluAnd;
            cmdOrr:  aluCtrlD = aluOrr;
            default: regWriteD = 1'b0; // Outside the subset, no effect
          endcase
        end
        opMem: begin
          aluSrcD   = 1'b1;     // Base + offset, always add
          immSrcD   = immMem12;
          regWriteD = loadBit;
          memToRegD = loadBit;
          memWriteD = !loadBit;
        end
        default: ; // Branches and the rest are not decoded
      endcase
    end
  end

  // Immediate extender
  always_comb begin
    case (immSrcD)
      immDp8:   extImmD = {24'b0, instrD[7:0]};
      immMem12: extImmD = {20'b0, instrD[11:0]};
    endcase
  end

  regFile rf0 (
    .clk (clk),
    .ra1 (ra1D),
    .ra2 (ra2D),
    .wa3 (wa3W),
    .we3 (regWriteW),
    .wd3 (resultW),
    .r15 (pcPlus4F),
    .rd1 (rd1D),
    .rd2 (rd2D)
  );

  // D/E control, a flush inserts a bubble
  always_ff @(posedge clk) begin
    if (!rstN || flushE) begin
      aluCtrlE  <= aluAdd;
      aluSrcE   <= 1'b0;
      regWriteE <= 1'b0;
      memWriteE <= 1'b0;
      memToRegE <= 1'b0;
    end else begin
      aluCtrlE  <= aluCtrlD;
      aluSrcE   <= aluSrcD;
      regWriteE <= regWriteD;
      memWriteE <= memWriteD;
      memToRegE <= memToRegD;
    end
  end

  // D/E payload
  always_ff @(posedge clk) begin
    rd1E    <= rd1D;
    rd2E    <= rd2D;
    extImmE <= extImmD;
    wa3E    <= wa3D;
    ra1E    <= ra1D; // Kept for the forwarding compare
    ra2E    <= ra2D;
  end

endmodule

//--- design/executeStage.sv
module executeStage (
  input  logic               clk,
  input  logic               rstN,
  input  armIsaPkg::wordT    rd1E,
  input  armIsaPkg::wordT    rd2E,
  input  armIsaPkg::wordT    extImmE,
  input  armIsaPkg::regAddrT wa3E,
  input  armIsaPkg::aluCtrlT aluCtrlE,
  input  logic               aluSrcE,
  input  logic               regWriteE,
  input  logic               memWriteE,
  input  logic               memToRegE,
  input  pipeCfgPkg::fwdSelT forwardA,
  input  pipeCfgPkg::fwdSelT forwardB,
  input  armIsaPkg::wordT    resultW,
  output armIsaPkg::wordT    aluOutM,   // Data address for LDR/STR
  output armIsaPkg::wordT    writeDataM,
  output armIsaPkg::regAddrT wa3M,
  output logic               regWriteM,
  output logic               memWriteM,
  output logic               memToRegM
);
  import armIsaPkg::*;
  import pipeCfgPkg::*;

  wordT srcA;
  wordT srcB;
  wordT writeDataE; // Forwarded rd2, the store data
  wordT aluResultE;

  // Bypass mux shared by both operands
  function automatic wordT fwdMux(fwdSelT sel, wordT regVal, wordT wVal, wordT mVal);
    case (sel)
      fwdResultW: return wVal;
      fwdAluOutM: return mVal;
      default:    return regVal;
    endcase
  endfunction

  assign srcA       = fwdMux(forwardA, rd1E, resultW, aluOutM);
  assign writeDataE = fwdMux(forwardB, rd2E, resultW, aluOutM);
  assign srcB       = aluSrcE ? extImmE : writeDataE; // Immediate or register operand

  // ALU, no flags
  always_comb begin
    case (aluCtrlE)
      aluAdd: aluResultE = srcA + srcB;
      aluSub: aluResultE = srcA - srcB;
      aluAnd: aluResultE = srcA & srcB;
      aluOrr: aluResultE = srcA | srcB;
    endcase
  end

  // E/M control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteM <= 1'b0;
      memWriteM <= 1'b0;
      memToRegM <= 1'b0;
    end else begin
      regWriteM <= regWriteE;
      memWriteM <= memWriteE;
      memToRegM <= memToRegE;
    end
  end

  // E/M payload
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
    wa3M       <= wa3E;
  end

endmodule

//--- design/fetchStage.sv
module fetchStage #(
  parameter armIsaPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            rstN,
  input  logic            stallF,
  input  logic            stallD,
  input  armIsaPkg::wordT instrF,   // Returned by imem in the same cycle
  output armIsaPkg::wordT pcF,
  output armIsaPkg::wordT pcPlus4F, // Also PC+8 of the instruction in decode
  output armIsaPkg::wordT instrD
);

  // Sequential fetch only, nothing ever redirects the PC
  assign pcPlus4F = pcF + 32'd4;

  // Program counter
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcF <= resetPc;
    end else if (!stallF) begin
      pcF <= pcPlus4F;
    end
    // Stalled: refetch the same word next cycle
  end

  // F/D instruction register
  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrD <= '0; // Decoded as a bubble
    end else if (!stallD) begin
      instrD <= instrF;
    end
  end

endmodule

//--- design/hazardUnit.sv
module hazardUnit (
  input  armIsaPkg::regAddrT ra1D,
  input  armIsaPkg::regAddrT ra2D,
  input  armIsaPkg::regAddrT ra1E,
  input  armIsaPkg::regAddrT ra2E,
  input  armIsaPkg::regAddrT wa3E,
  input  armIsaPkg::regAddrT wa3M,
  input  armIsaPkg::regAddrT wa3W,
  input  logic               memToRegE, // LDR in execute
  input  logic               regWriteM,
  input  logic               regWriteW,
  output pipeCfgPkg::fwdSelT forwardA,
  output pipeCfgPkg::fwdSelT forwardB,
  output logic               stallF,
  output logic               stallD,
  output logic               flushE
);
  import pipeCfgPkg::*;

  logic match1EM;
  logic match1EW;
  logic match2EM;
  logic match2EW;
  logic match12DE;
  logic ldrStall;

  // Destination vs source compares
  assign match1EM  = (wa3M == ra1E);
  assign match1EW  = (wa3W == ra1E);
  assign match2EM  = (wa3M == ra2E);
  assign match2EW  = (wa3W == ra2E);
  assign match12DE = (wa3E == ra1D) || (wa3E == ra2D); // Either decode source

  // M has priority as it holds the younger value
  function automatic fwdSelT pickFwd(logic hitM, logic hitW);
    if (hitM) begin
      return fwdAluOutM;
    end else if (hitW) begin
      return fwdResultW;
    end
    return fwdReg;
  endfunction

  // Hits qualified by the write enable of their stage
  assign forwardA = pickFwd(match1EM && regWriteM, match1EW && regWriteW);
  assign forwardB = pickFwd(match2EM && regWriteM, match2EW && regWriteW);

  // Load data only exists in W so the user waits one cycle
  assign ldrStall = match12DE && memToRegE;

  assign stallF = ldrStall;
  assign stallD = ldrStall;
  assign flushE = ldrStall; // Bubble into E while D holds

endmodule

//--- design/memWbStage.sv
module memWbStage (
  input  logic               clk,
  input  logic               rstN,
  input  armIsaPkg::wordT    aluOutM,
  input  armIsaPkg::wordT    readDataM, // Combinational from dmem
  input  armIsaPkg::regAddrT wa3M,
  input  logic               regWriteM,
  input  logic               memToRegM,
  output logic               regWriteW,
  output armIsaPkg::regAddrT wa3W,
  output armIsaPkg::wordT    resultW
);
  import armIsaPkg::*;

  logic memToRegW;
  wordT aluOutW;
  wordT readDataW;

  // M/W control
  always_ff @(posedge clk) begin
    if (!rstN) begin
      regWriteW <= 1'b0;
      memToRegW <= 1'b0;
    end else begin
      regWriteW <= regWriteM;
      memToRegW <= memToRegM;
    end
  end

  // M/W payload, load data captured here
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
    wa3W      <= wa3M;
  end

  // Writeback result, also the W forwarding source
  assign resultW = memToRegW ? readDataW : aluOutW;

endmodule

//--- design/pipeCfgPkg.sv
package pipeCfgPkg;

  // Operand source for each ALU input, picked by the hazard unit
  typedef enum logic [1:0] {
    fwdReg     = 2'b00, // Value read in decode
    fwdResultW = 2'b01, // Writeback result
    fwdAluOutM = 2'b10  // ALU output sitting in the memory stage
  } fwdSelT;

  // First fetch address out of reset
  localparam armIsaPkg::wordT defaultResetPc = 32'h0000_0000;

endpackage

//--- design/regFile.sv
module regFile (
  input  logic               clk,
  input  armIsaPkg::regAddrT ra1,
  input  armIsaPkg::regAddrT ra2,
  input  armIsaPkg::regAddrT wa3,
  input  logic               we3,
  input  armIsaPkg::wordT    wd3,
  input  armIsaPkg::wordT    r15, // PC+8 of the reading instruction
  output armIsaPkg::wordT    rd1,
  output armIsaPkg::wordT    rd2
);
  import armIsaPkg::*;

  wordT rf [0:14]; // r0..r14 only, r15 lives in fetch

  logic writeOk;

  assign writeOk = we3 && (wa3 != 4'd15); // Writes to the PC are dropped

  always_ff @(posedge clk) begin
    if (writeOk) begin
      rf[wa3] <= wd3;
    end
  end

  // Write-through so W and D can share a cycle
  assign rd1 = (ra1 == 4'd15)             ? r15 :
               (writeOk && (wa3 == ra1))  ? wd3 :
                                            rf[ra1];

  assign rd2 = (ra2 == 4'd15)             ? r15 :
               (writeOk && (wa3 == ra2))  ? wd3 :
                                            rf[ra2];

endmodule

//--- sim/armPipeTb.sv
module armPipeTb;
  timeunit 1ns;
  timeprecision 100ps;
  import armIsaPkg::*;
  import pipeCfgPkg::*;

  localparam int   progLen    = 300;
  localparam int   clkPeriod  = 40;
  localparam int   imemWords  = 1024;
  localparam int   dmemWords  = 64;
  localparam wordT resetPcTb  = defaultResetPc;
  localparam int   watchdogNs = (progLen * 2 + 20) * clkPeriod; // Every instruction may stall once
  localparam int   kindDp     = 0;
  localparam int   kindLdr    = 1;
  localparam int   kindStr    = 2;

  logic    clk = 1'b0;
  logic    rstN;
  wordT    instrF;
  wordT    readDataM;
  wordT    pcF;
  wordT    aluOutM;
  wordT    writeDataM;
  wordT    resultW;
  logic    memWriteM;
  logic    regWriteW;
  regAddrT wa3W;

  wordT        imem [0:imemWords-1];
  wordT        dmem [0:dmemWords-1];     // Seen by the DUT
  wordT        modelMem [0:dmemWords-1]; // ISA model copy
  wordT        modelReg [0:15];
  int          kindA [0:progLen-1];
  logic [3:0]  cmdA [0:progLen-1];
  logic        immOpA [0:progLen-1];
  regAddrT     rdA [0:progLen-1];
  regAddrT     rnA [0:progLen-1];
  regAddrT     rmA [0:progLen-1];
  logic [11:0] immA [0:progLen-1];

  regAddrT expWa3Q [$]; // Expected writebacks in program order
  wordT    expResQ [$];
  wordT    expAddrQ [$]; // Expected stores
  wordT    expDataQ [$];
  integer  seed;

  armPipeTop #(.resetPc(defaultResetPc)) dut0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrF     (instrF),
    .readDataM  (readDataM),
    .pcF        (pcF),
    .aluOutM    (aluOutM),
    .writeDataM (writeDataM),
    .resultW    (resultW),
    .memWriteM  (memWriteM),
    .regWriteW  (regWriteW),
    .wa3W       (wa3W)
  );

  bind hazardUnit hazardUnit_properties props0 (
    .clk      (armPipeTb.clk),
    .rstN     (armPipeTb.rstN),
    .stallF   (stallF),
    .stallD   (stallD),
    .flushE   (flushE),
    .forwardA (forwardA),
    .forwardB (forwardB)
  );

  initial begin
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic abortRun(string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic reportMismatch(string sigName, wordT expVal, wordT actVal);
    abortRun($sformatf("** Error at %0d ns: %s expected %h, actual %h",
                       $time, sigName, expVal, actVal));
  endtask

  task automatic checkWrite(regAddrT expWa3, wordT expRes);
    if (wa3W !== expWa3) reportMismatch("wa3W", wordT'(expWa3), wordT'(wa3W));
    else if (resultW !== expRes) reportMismatch("resultW", expRes, resultW);
  endtask

  task automatic checkStore(wordT expAddr, wordT expData);
    if (aluOutM !== expAddr) reportMismatch("aluOutM", expAddr, aluOutM);
    else if (writeDataM !== expData) reportMismatch("writeDataM", expData, writeDataM);
  endtask

  task automatic checkPc(wordT expPc);
    if (pcF !== expPc) reportMismatch("pcF", expPc, pcF);
  endtask

  // Condition AL with S clear and no rotate or shift on operand2
  function automatic wordT encodeDp(logic [3:0] cmd, logic immOp, regAddrT rn, regAddrT rd,
                                    logic [11:0] op2);
    return {4'hE, opDp, immOp, cmd, 1'b0, rn, rd, op2};
  endfunction

  // Pre-indexed positive immediate offset without writeback
  function automatic wordT encodeMem(logic load, regAddrT rn, regAddrT rd, logic [11:0] imm12);
    return {4'hE, opMem, 5'b01100, load, rn, rd, imm12};
  endfunction

  function automatic logic [3:0] pickCmd(logic [1:0] sel);
    case (sel)
      2'd0:    return cmdAdd;
      2'd1:    return cmdSub;
      2'd2:    return cmdAnd;
      default: return cmdOrr;
    endcase
  endfunction

  function automatic wordT fillWord(int idx);
    return (32'h1357_9bdf ^ (wordT'(idx) * 32'h0104_1041)) + {idx[5:0], 26'd0};
  endfunction

  function automatic wordT readModel(regAddrT idx, wordT pc);
    return (idx == 4'd15) ? pc + 32'd8 : modelReg[idx];
  endfunction

  task automatic buildProgram();
    int          i;
    logic [31:0] rnd;
    logic        prevLoad;
    regAddrT     prevRd;
    prevLoad = 1'b0;
    prevRd   = '0;
    for (i = 0; i < imemWords; i++) begin
      imem[i] = encodeDp(cmdOrr, 1'b0, 4'd8, 4'd8, 12'd8); // ORR r8,r8,r8 as filler
    end
    for (i = 0; i < progLen; i++) begin
      rnd       = $random(seed);
      rdA[i]    = {1'b0, rnd[8:6]};
      rnA[i]    = (rnd[17:15] == 3'd0) ? 4'd15 : {1'b0, rnd[11:9]};
      rmA[i]    = (rnd[20:18] == 3'd0) ? 4'd15 : {1'b0, rnd[14:12]};
      immOpA[i] = rnd[5];
      cmdA[i]   = pickCmd(rnd[4:3]);
      immA[i]   = {4'b0, rnd[28:21]};
      if (i < 8) begin // ADD ri, pc, #imm gives r0..r7 known values
        kindA[i]  = kindDp;
        cmdA[i]   = cmdAdd;
        immOpA[i] = 1'b1;
        rdA[i]    = regAddrT'(i);
        rnA[i]    = 4'd15;
      end else if (rnd[2:0] < 3'd4) begin
        kindA[i] = kindDp;
      end else begin
        kindA[i] = (rnd[2:0] < 3'd6) ? kindLdr : kindStr;
        rnA[i]   = {1'b0, rnd[11:9]}; // Base stays in r0..r7
        immA[i]  = {6'b0, rnd[26:21]};
      end
      if (prevLoad && rnd[31]) rnA[i] = prevRd; // Load-use on the first source
      if (prevLoad && rnd[30]) rmA[i] = prevRd;
      prevLoad = (kindA[i] == kindLdr);
      prevRd   = rdA[i];
      if (kindA[i] == kindDp) begin
        imem[i] = encodeDp(cmdA[i], immOpA[i], rnA[i], rdA[i],
                           immOpA[i] ? immA[i] : {8'b0, rmA[i]});
      end else begin
        imem[i] = encodeMem(kindA[i] == kindLdr, rnA[i], rdA[i], immA[i]);
      end
    end
  endtask

  // In-order ISA model that fills the expected queues
  task automatic runModel();
    int   i;
    wordT pc;
    wordT a;
    wordT b;
    wordT res;
    wordT addr;
    for (i = 0; i < dmemWords; i++) begin
      dmem[i]     = fillWord(i);
      modelMem[i] = fillWord(i);
    end
    for (i = 0; i < 16; i++) modelReg[i] = '0;
    for (i = 0; i < progLen; i++) begin
      pc   = resetPcTb + 4 * i;
      a    = readModel(rnA[i], pc);
      b    = immOpA[i] ? {20'b0, immA[i]} : readModel(rmA[i], pc);
      addr = a + {20'b0, immA[i]}; // Data address wraps in 64 words
      if (kindA[i] == kindDp) begin
        case (cmdA[i])
          cmdAdd:  res = a + b;
          cmdSub:  res = a - b;
          cmdAnd:  res = a & b;
          default: res = a | b;
        endcase
      end else begin
        res = modelMem[addr[7:2]];
      end
      if (kindA[i] == kindStr) begin
        expAddrQ.push_back(addr);
        expDataQ.push_back(modelReg[rdA[i]]);
        modelMem[addr[7:2]] = modelReg[rdA[i]];
      end else begin
        modelReg[rdA[i]] = res;
        expWa3Q.push_back(rdA[i]);
        expResQ.push_back(res);
      end
    end
  endtask

  // Memories answer 2 ns after the edge once pcF and aluOutM have settled
  always @(posedge clk) begin : driveMemories
    wordT pcOff;
    #2;
    pcOff     = pcF - resetPcTb;
    instrF    = imem[pcOff[11:2]];
    readDataM = dmem[aluOutM[7:2]];
  end

  // Sampled mid-cycle where every output is stable
  always @(negedge clk) begin
    if (dut0.hazard0.props0.assertFails != 0) abortRun("A hazard unit assertion failed");
    if (!rstN) begin
      if (regWriteW !== 1'b0 || memWriteM !== 1'b0) abortRun("Write strobe active in reset");
    end else begin
      if (regWriteW) begin
        if (expWa3Q.size() == 0) begin
          if (wa3W !== 4'd8) abortRun("Register write after the last expected one");
        end else begin
          checkWrite(expWa3Q.pop_front(), expResQ.pop_front());
        end
      end
      if (memWriteM) begin
        if (expAddrQ.size() == 0) begin
          abortRun("Store seen after the last expected one");
        end else begin
          checkStore(expAddrQ.pop_front(), expDataQ.pop_front());
          dmem[aluOutM[7:2]] = writeDataM;
        end
      end
    end
  end

  initial begin
    #(watchdogNs);
    abortRun($sformatf("Timeout after %0d ns with events still outstanding", watchdogNs));
  end

  initial begin
    seed      = 32'h8a83_5b32;
    rstN      = 1'b0;
    instrF    = '0;
    readDataM = '0;
    buildProgram();
    runModel();
    repeat (2) @(posedge clk);
    #2;
    rstN = 1'b1;
    checkPc(resetPcTb);
    while (expWa3Q.size() != 0 || expAddrQ.size() != 0) @(posedge clk);
    repeat (8) @(posedge clk); // Only filler writes may follow
    if (dut0.hazard0.props0.assertFails == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      abortRun("A hazard unit assertion failed");
    end
  end

endmodule

//--- sim/hazardUnit_properties.sv
module hazardUnit_properties (
  input logic               clk,
  input logic               rstN,
  input logic               stallF,
  input logic               stallD,
  input logic               flushE,
  input pipeCfgPkg::fwdSelT forwardA,
  input pipeCfgPkg::fwdSelT forwardB
);
  timeunit 1ns;
  timeprecision 100ps;
  import pipeCfgPkg::*;

  logic settled = 1'b0; // Low until the first edge has cleared the pipeline registers
  int   assertFails = 0;  // Read by the testbench monitor

  always @(posedge clk) begin
    settled <= 1'b1;
  end

  // Fetch and decode hold together
  stallPair: assert property (@(posedge clk) disable iff (!settled) stallF == stallD)
    else begin assertFails++; $error("stallF and stallD disagree"); end

  flushNeedsStall: assert property (@(posedge clk) disable iff (!settled) flushE |-> stallD)
    else begin assertFails++; $error("flushE raised without stallD"); end

  fwdALegal: assert property (@(posedge clk) disable iff (!settled)
    forwardA inside {fwdReg, fwdResultW, fwdAluOutM})
    else begin assertFails++; $error("forwardA outside its encoding"); end

  fwdBLegal: assert property (@(posedge clk) disable iff (!settled)
    forwardB inside {fwdReg, fwdResultW, fwdAluOutM})
    else begin assertFails++; $error("forwardB outside its encoding"); end

  // The bubble in E clears the load match, so a stall is one cycle long
  stallOneCycle: assert property (@(posedge clk) disable iff (!settled) stallD |=> !stallD)
    else begin assertFails++; $error("stall held for two cycles"); end

  resetQuiet: assert property (@(posedge clk) disable iff (!settled)
    !rstN |-> (!stallF && !stallD && !flushE && forwardA == fwdReg && forwardB == fwdReg))
    else begin assertFails++; $error("hazard controls active during reset"); end

endmodule
